// ==== bench/frontend_props.sv ====
`default_nettype none

module frontend_props (
    input wire                        clk,
    input wire                        arst_n,
    input wire                        fetch_en,
    input wire                        buffer_full,
    input wire                        inst_valid,
    input wire                        send_en,
    input wire                        branch_flush,
    input wire frontend_pkg::addr_t   inst_pc,
    input wire frontend_pkg::ib_cnt_t count
);
    import frontend_pkg::*;

    int fail_count;

    initial fail_count = 0;

    no_fetch_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        !(fetch_en && buffer_full))
        else begin
            fail_count++;
            $error("fetch_en is high while buffer_full is high");
        end

    count_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        count <= ib_cnt_t'(ib_depth))
        else begin
            fail_count++;
            $error("buffer count %0d is above the depth", count);
        end

    // Head must wait for the backend
    head_held: assert property (@(posedge clk) disable iff (!arst_n)
        inst_valid && !send_en && !branch_flush |=> inst_valid && $stable(inst_pc))
        else begin
            fail_count++;
            $error("head entry changed or vanished without send_en");
        end

    flush_empties: assert property (@(posedge clk) disable iff (!arst_n)
        branch_flush |=> !inst_valid)
        else begin
            fail_count++;
            $error("buffer not empty after branch_flush");
        end

    // Response in the cycle after a flush is stale
    stale_dropped: assert property (@(posedge clk) disable iff (!arst_n)
        branch_flush |-> ##2 (count == '0))
        else begin
            fail_count++;
            $error("stale cache response was written after branch_flush");
        end

endmodule

bind inst_buffer frontend_props frontend_props_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .fetch_en     (fetch_en),
    .buffer_full  (buffer_full),
    .inst_valid   (inst_valid),
    .send_en      (send_en),
    .branch_flush (branch_flush),
    .inst_pc      (inst_pc),
    .count        (count)
);

`default_nettype wire

// ==== bench/frontend_tb.sv ====
`default_nettype none

module frontend_tb;
    import frontend_pkg::*;

    localparam inst_t inst_pattern = 32'h5a5a_0000;
    localparam int    cycle_limit  = 2000;
    localparam addr_t train_pc     = 32'h8000_0040;
    localparam addr_t train_target = 32'h8000_0100;

    logic clk, arst_n, icache_stall, icache_valid, send_en;
    logic update_valid, update_taken, branch_flush;
    inst_t icache_inst, inst;
    addr_t icache_pc, update_pc, update_target, branch_actual_addr;
    addr_t fetch_pc, inst_pc, pred_target;
    logic  fetch_en, inst_valid, pred_taken;

    // Reference BTB and direction counters
    logic     ref_valid  [btb_entries];
    btb_tag_t ref_tag    [btb_entries];
    addr_t    ref_target [btb_entries];
    bht_ctr_t ref_ctr    [btb_entries];

    integer seed;
    int     cycles, checks, errors, delivered, tests_run, tests_failed, errs_before;
    logic   random_mode, after_flush, saw_taken_p, saw_nt_p, cache_accept;
    addr_t  exp_pc, first_flush_pc, flush_addr, cache_pc;

    frontend_top frontend_top_i (.*);

    always #4 clk = ~clk;

    function automatic int total_errors();
        return errors + frontend_top_i.inst_buffer_i.frontend_props_i.fail_count;
    endfunction

    function automatic logic predict_taken(addr_t pc);
        return ref_valid[pc[5:2]] && (ref_tag[pc[5:2]] == pc[31:6])
            && (ref_ctr[pc[5:2]] >= 2'd2);
    endfunction

    function automatic void train_model(addr_t pc, logic taken, addr_t target);
        btb_idx_t idx;
        logic     hit;
        idx = pc[5:2];
        hit = ref_valid[idx] && (ref_tag[idx] == pc[31:6]);
        if (taken) begin
            ref_ctr[idx]    = !hit ? 2'd2 : (ref_ctr[idx] == 2'd3) ? 2'd3 : ref_ctr[idx] + 2'd1;
            ref_valid[idx]  = 1'b1;
            ref_tag[idx]    = pc[31:6];
            ref_target[idx] = target;
        end else if (hit && ref_ctr[idx] != 2'd0) begin
            ref_ctr[idx] = ref_ctr[idx] - 2'd1;
        end
    endfunction

    task automatic expect_equal(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_entry();
        logic taken;
        taken = predict_taken(exp_pc);
        expect_equal("inst_pc", inst_pc, exp_pc);
        expect_equal("inst", inst, exp_pc ^ inst_pattern);
        expect_equal("pred_taken", pred_taken, taken);
        if (taken) begin
            expect_equal("pred_target", pred_target, ref_target[exp_pc[5:2]]);
        end
        if (after_flush) begin
            first_flush_pc = inst_pc;
            after_flush = 1'b0;
        end
        if (inst_pc == train_pc) begin
            saw_taken_p |= pred_taken;
            saw_nt_p    |= !pred_taken;
        end
        exp_pc = taken ? ref_target[exp_pc[5:2]] : exp_pc + 32'd4;
        delivered++;
    endtask

    ////////////////////////////////////////
    // Cache model, delivery check, timeout
    ////////////////////////////////////////

    always @(posedge clk) begin
        cache_accept = arst_n && fetch_en && !icache_stall;
        cache_pc = fetch_pc;
        #1;
        icache_valid = cache_accept;
        icache_pc = cache_pc;
        icache_inst = cache_pc ^ inst_pattern;
    end

    always @(posedge clk) begin
        if (arst_n && branch_flush) begin
            exp_pc = branch_actual_addr;
            after_flush = 1'b1;
        end else if (arst_n && inst_valid && send_en) begin
            check_entry();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (random_mode) begin
            icache_stall = $random(seed) & 1;
            send_en = ($random(seed) & 3) != 0;
        end
    endtask

    task automatic wait_deliveries(int n);
        int target;
        target = delivered + n;
        while (delivered < target) begin
            next_cycle();
        end
    endtask

    task automatic train_branch(addr_t pc, logic taken, addr_t target);
        next_cycle();
        update_valid = 1'b1;
        update_pc = pc;
        update_taken = taken;
        update_target = target;
        train_model(pc, taken, target);
        next_cycle();
        update_valid = 1'b0;
    endtask

    task automatic flush_to(addr_t addr);
        next_cycle();
        branch_flush = 1'b1;
        branch_actual_addr = addr;
        send_en = 1'b0;
        next_cycle();
        branch_flush = 1'b0;
        send_en = 1'b1;
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (total_errors() != errs_before) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s", tests_run, name,
                 (total_errors() == errs_before) ? "ok" : "failed");
        errs_before = total_errors();
    endtask

    initial begin
        seed = 27266;
        {clk, arst_n, icache_stall, icache_valid, send_en} = '0;
        {update_valid, update_taken, branch_flush, random_mode} = '0;
        {icache_inst, icache_pc, update_pc, update_target, branch_actual_addr} = '0;
        {cycles, checks, errors, delivered, tests_run, tests_failed, errs_before} = '0;
        {after_flush, saw_taken_p, saw_nt_p} = '0;
        exp_pc = reset_vector;
        for (int i = 0; i < btb_entries; i++) begin
            ref_valid[i] = 1'b0;
            ref_ctr[i] = 2'd1;
        end
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;
        send_en = 1'b1;

        wait_deliveries(16);
        end_test("sequential fetch");

        // Backend holds off while the queue fills and keeps its head
        send_en = 1'b0;
        repeat (20) begin
            next_cycle();
            expect_equal("inst_valid", inst_valid, 1'b1);
            expect_equal("inst_pc", inst_pc, exp_pc);
        end
        expect_equal("buffer_full", frontend_top_i.buffer_full, 1'b1);
        send_en = 1'b1;
        wait_deliveries(12);
        end_test("back-pressure");

        random_mode = 1'b1;
        wait_deliveries(30);
        random_mode = 1'b0;
        icache_stall = 1'b0;
        send_en = 1'b1;
        end_test("cache stall");

        flush_addr = $random(seed) & 32'hffff_fffc;
        flush_to(flush_addr);
        wait_deliveries(12);
        expect_equal("first pc after flush", first_flush_pc, flush_addr);
        end_test("flush");

        train_branch(train_pc, 1'b1, train_target);
        flush_to(train_pc - 32'd16);
        wait_deliveries(12);
        expect_equal("taken prediction seen", saw_taken_p, 1'b1);
        end_test("training taken");

        saw_nt_p = 1'b0;
        train_branch(train_pc, 1'b0, train_target);
        train_branch(train_pc, 1'b0, train_target);
        flush_to(train_pc - 32'd8);
        wait_deliveries(8);
        expect_equal("not-taken prediction seen", saw_nt_p, 1'b1);
        end_test("training not-taken");

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, total_errors());
        if (total_errors() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== frontend_top.f ====
source/frontend_pkg.sv
source/pc_reg.sv
source/bpu.sv
source/inst_buffer.sv
source/frontend_top.sv
bench/frontend_props.sv
bench/frontend_tb.sv

// ==== source/bpu.sv ====
`default_nettype none

module bpu (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire frontend_pkg::addr_t fetch_pc,
    input  wire                      update_valid,
    input  wire frontend_pkg::addr_t update_pc,
    input  wire                      update_taken,
    input  wire frontend_pkg::addr_t update_target,
    output logic                     pred_taken_f,
    output frontend_pkg::addr_t      pred_target_f
);
    import frontend_pkg::*;

    ////////////////////////////////////////
    // BTB and direction counters
    ////////////////////////////////////////

    logic [btb_entries-1:0] btb_valid;
    bht_ctr_t               btb_ctr    [btb_entries];
    btb_tag_t               btb_tag    [btb_entries];
    addr_t                  btb_target [btb_entries];

    btb_idx_t f_idx;
    btb_tag_t f_tag;
    logic     f_hit;

    btb_idx_t u_idx;
    btb_tag_t u_tag;
    logic     u_hit;
    logic     ctr_we;
    bht_ctr_t u_ctr_next;

    ////////////////////////////////////////
    // Lookup on the fetch address
    ////////////////////////////////////////

    assign f_idx = fetch_pc[5:2];
    assign f_tag = fetch_pc[31:6];
    assign f_hit = btb_valid[f_idx] && (btb_tag[f_idx] == f_tag);

    // Taken only on a hit with counter in the upper half
    assign pred_taken_f  = f_hit && (btb_ctr[f_idx] >= ctr_weak_t);
    assign pred_target_f = btb_target[f_idx];

    ////////////////////////////////////////
    // Training from the backend
    ////////////////////////////////////////

    assign u_idx = update_pc[5:2];
    assign u_tag = update_pc[31:6];
    assign u_hit = btb_valid[u_idx] && (btb_tag[u_idx] == u_tag);

    // Not-taken only trains an entry that already belongs to this pc
    assign ctr_we = update_valid && (update_taken || u_hit);

    always_comb begin
        u_ctr_next = btb_ctr[u_idx];
        if (update_taken) begin
            if (!u_hit) begin
                // New owner of the entry
                u_ctr_next = ctr_weak_t;
            end else if (btb_ctr[u_idx] != ctr_strong_t) begin
                u_ctr_next = btb_ctr[u_idx] + 2'd1;
            end
        end else if (btb_ctr[u_idx] != ctr_strong_nt) begin
            u_ctr_next = btb_ctr[u_idx] - 2'd1;
        end
    end

    // Valid bits and counters
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            btb_valid <= '0;
            for (int i = 0; i < btb_entries; i++) begin
                btb_ctr[i] <= ctr_reset;
            end
        end else begin
            if (update_valid && update_taken) begin
                btb_valid[u_idx] <= 1'b1;
            end
            if (ctr_we) begin
                btb_ctr[u_idx] <= u_ctr_next;
            end
        end
    end

    // Tag and target, written on taken updates only
    always_ff @(posedge clk) begin
        if (update_valid && update_taken) begin
            btb_tag[u_idx]    <= u_tag;
            btb_target[u_idx] <= update_target;
        end
    end

endmodule

`default_nettype wire

// ==== source/frontend_pkg.sv ====
`default_nettype none

package frontend_pkg;

    ////////////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////////////

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // BTB index is pc[5:2], tag is pc[31:6]
    typedef logic [3:0]  btb_idx_t;
    typedef logic [25:0] btb_tag_t;

    typedef logic [2:0] ib_ptr_t;
    // One bit wider than the pointer so that a full queue shows
    typedef logic [3:0] ib_cnt_t;

    typedef logic [1:0] bht_ctr_t;

    ////////////////////////////////////////
    // Constants
    ////////////////////////////////////////

    localparam addr_t reset_vector = 32'h1c00_0000;
    localparam addr_t inst_bytes   = 32'd4;

    localparam int btb_entries = 16;
    localparam int ib_depth    = 8;

    // Direction counter, upper half predicts taken
    localparam bht_ctr_t ctr_strong_nt = 2'd0;
    localparam bht_ctr_t ctr_weak_nt   = 2'd1;
    localparam bht_ctr_t ctr_weak_t    = 2'd2;
    localparam bht_ctr_t ctr_strong_t  = 2'd3;
    localparam bht_ctr_t ctr_reset     = ctr_weak_nt;

endpackage

`default_nettype wire

// ==== source/frontend_top.sv ====
`default_nettype none

module frontend_top (
    input  wire                      clk,
    input  wire                      arst_n,

    // Instruction cache
    output frontend_pkg::addr_t      fetch_pc,
    output logic                     fetch_en,
    input  wire                      icache_stall,
    input  wire                      icache_valid,
    input  wire frontend_pkg::inst_t icache_inst,
    input  wire frontend_pkg::addr_t icache_pc,

    // Delivery to the backend
    output logic                     inst_valid,
    output frontend_pkg::inst_t      inst,
    output frontend_pkg::addr_t      inst_pc,
    output logic                     pred_taken,
    output frontend_pkg::addr_t      pred_target,
    input  wire                      send_en,

    // Training and redirect
    input  wire                      update_valid,
    input  wire frontend_pkg::addr_t update_pc,
    input  wire                      update_taken,
    input  wire frontend_pkg::addr_t update_target,
    input  wire                      branch_flush,
    input  wire frontend_pkg::addr_t branch_actual_addr
);
    import frontend_pkg::*;

    logic  pred_taken_f;
    addr_t pred_target_f;
    logic  buffer_full;

    ////////////////////////////////////////
    // Fetch address
    ////////////////////////////////////////

    pc_reg pc_reg_i (
        .clk                (clk),
        .arst_n             (arst_n),
        .icache_stall       (icache_stall),
        .buffer_full        (buffer_full),
        .branch_flush       (branch_flush),
        .branch_actual_addr (branch_actual_addr),
        .pred_taken_f       (pred_taken_f),
        .pred_target_f      (pred_target_f),
        .fetch_pc           (fetch_pc),
        .fetch_en           (fetch_en)
    );

    // Same-cycle prediction on fetch_pc
    bpu bpu_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .fetch_pc      (fetch_pc),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target),
        .pred_taken_f  (pred_taken_f),
        .pred_target_f (pred_target_f)
    );

    ////////////////////////////////////////
    // Instruction queue
    ////////////////////////////////////////

    inst_buffer inst_buffer_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .fetch_pc      (fetch_pc),
        .fetch_en      (fetch_en),
        .icache_stall  (icache_stall),
        .pred_taken_f  (pred_taken_f),
        .pred_target_f (pred_target_f),
        .icache_valid  (icache_valid),
        .icache_inst   (icache_inst),
        .icache_pc     (icache_pc),
        .branch_flush  (branch_flush),
        .send_en       (send_en),
        .buffer_full   (buffer_full),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .inst_pc       (inst_pc),
        .pred_taken    (pred_taken),
        .pred_target   (pred_target)
    );

endmodule

`default_nettype wire

// ==== source/inst_buffer.sv ====
`default_nettype none

module inst_buffer (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire frontend_pkg::addr_t fetch_pc,
    input  wire                      fetch_en,
    input  wire                      icache_stall,
    input  wire                      pred_taken_f,
    input  wire frontend_pkg::addr_t pred_target_f,
    input  wire                      icache_valid,
    input  wire frontend_pkg::inst_t icache_inst,
    input  wire frontend_pkg::addr_t icache_pc,
    input  wire                      branch_flush,
    input  wire                      send_en,
    output logic                     buffer_full,
    output logic                     inst_valid,
    output frontend_pkg::inst_t      inst,
    output frontend_pkg::addr_t      inst_pc,
    output logic                     pred_taken,
    output frontend_pkg::addr_t      pred_target
);
    import frontend_pkg::*;

    logic fetch_accept;
    logic push;
    logic pop;

    // Prediction of the fetch now in the cache
    logic  side_valid;
    addr_t side_pc;
    logic  side_taken;
    addr_t side_target;

    // Response right after a flush is stale
    logic drop_q;

    inst_t q_inst   [ib_depth];
    addr_t q_pc     [ib_depth];
    logic  q_taken  [ib_depth];
    addr_t q_target [ib_depth];

    ib_ptr_t head;
    ib_ptr_t tail;
    ib_cnt_t count;

    assign fetch_accept = fetch_en & ~icache_stall;

    // Response must match the fetch its prediction was taken for
    assign push = icache_valid & side_valid & ~drop_q & (icache_pc == side_pc);
    assign pop  = inst_valid & send_en;

    // In-flight fetch reserves a slot
    assign buffer_full = ib_cnt_t'(count + ib_cnt_t'(side_valid)) >= ib_cnt_t'(ib_depth);

    ////////////////////////////////////////
    // Pointers, count and flags
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            side_valid <= 1'b0;
            drop_q     <= 1'b0;
        end else if (branch_flush) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            side_valid <= 1'b0;
            drop_q     <= 1'b1;
        end else begin
            side_valid <= fetch_accept;
            drop_q     <= 1'b0;
            if (push) begin
                tail <= tail + 3'd1;
            end
            if (pop) begin
                head <= head + 3'd1;
            end
            count <= ib_cnt_t'(count + ib_cnt_t'(push) - ib_cnt_t'(pop));
        end
    end

    ////////////////////////////////////////
    // Payload
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (fetch_accept) begin
            side_pc     <= fetch_pc;
            side_taken  <= pred_taken_f;
            side_target <= pred_target_f;
        end
        if (push) begin
            q_inst[tail]   <= icache_inst;
            q_pc[tail]     <= icache_pc;
            q_taken[tail]  <= side_taken;
            q_target[tail] <= side_target;
        end
    end

    // Head entry goes straight to the backend
    assign inst_valid  = (count != '0);
    assign inst        = q_inst[head];
    assign inst_pc     = q_pc[head];
    assign pred_taken  = q_taken[head];
    assign pred_target = q_target[head];

endmodule

`default_nettype wire

// ==== source/pc_reg.sv ====
`default_nettype none

module pc_reg (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      icache_stall,
    input  wire                      buffer_full,
    input  wire                      branch_flush,
    input  wire frontend_pkg::addr_t branch_actual_addr,
    input  wire                      pred_taken_f,
    input  wire frontend_pkg::addr_t pred_target_f,
    output frontend_pkg::addr_t      fetch_pc,
    output logic                     fetch_en
);
    import frontend_pkg::*;

    logic  started;
    logic  fetch_accept;
    addr_t next_pc;

    // Fetch starts one edge after reset is released
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    assign fetch_en     = started & ~buffer_full;
    assign fetch_accept = fetch_en & ~icache_stall;

    ////////////////////////////////////////
    // Next fetch address
    ////////////////////////////////////////

    always_comb begin
        if (branch_flush) begin
            // Backend redirect beats everything
            next_pc = branch_actual_addr;
        end else if (!fetch_accept) begin
            next_pc = fetch_pc;
        end else if (pred_taken_f) begin
            next_pc = pred_target_f;
        end else begin
            next_pc = fetch_pc + inst_bytes;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_pc <= reset_vector;
        end else begin
            fetch_pc <= next_pc;
        end
    end

endmodule

`default_nettype wire
